//--- FpMiscUnit.f
verilog/FpTypes.sv
verilog/FpPipeIf.sv
verilog/FpOpDecoder.sv
verilog/FpClassifier.sv
verilog/FpCompareUnit.sv
verilog/FpExecUnit.sv
verilog/FpResultStage.sv
verilog/FpMiscUnit.sv
tb/FpClockGen.sv
tb/FpMiscUnit_assert.sv
tb/FpMiscUnitTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module FpMiscUnitTb -f FpMiscUnit.f -o FpMiscUnitSim
	./obj_dir/FpMiscUnitSim +verilator+error+limit+100 | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- tb/FpClockGen.sv
// clock and reset generator for the misc unit testbench.

`timescale 1ns/1ps

module FpClockGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period.
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk); // four reset cycles.
        #2 rstN = 1'b1;
    end
endmodule

//--- tb/FpMiscUnitTb.sv
// testbench for the misc unit with a directed table, a random stream and an in-order checker.

`timescale 1ns/1ps

module FpMiscUnitTb;
    localparam logic [6:0] F7SGNJ   = 7'h10;
    localparam logic [6:0] F7MINMAX = 7'h14;
    localparam logic [6:0] F7CMP    = 7'h50;
    localparam logic [6:0] F7CLS    = 7'h70;
    localparam logic [6:0] F7MVWX   = 7'h78;
    localparam int TIMEOUT = 20; // cycles allowed per result.
    localparam logic [9:0] LEGAL_OPS [11] = '{ // {funct7, funct3}.
        {F7SGNJ, 3'd0}, {F7SGNJ, 3'd1}, {F7SGNJ, 3'd2}, {F7MINMAX, 3'd0}, {F7MINMAX, 3'd1},
        {F7CMP, 3'd2}, {F7CMP, 3'd1}, {F7CMP, 3'd0}, {F7CLS, 3'd1}, {F7CLS, 3'd0}, {F7MVWX, 3'd0}
    };
    localparam logic [31:0] SPECIALS [10] = '{
        32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'hBF80_0000, 32'h7F80_0000,
        32'hFF80_0000, 32'h7FC0_0000, 32'h7F80_0001, 32'h0000_0001, 32'hFFC0_0000
    };

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] data;
        logic [1:0]  flags; // {illegal, invalid}.
    } stimEntry_t;

    logic        clk;
    logic        rstN;
    logic        issueValid;
    logic [31:0] instr;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic        resultValid;
    logic [4:0]  resultRd;
    logic [31:0] resultData;
    logic        resultInvalid;
    logic        illegalInstr;
    stimEntry_t  stimTable [$];
    logic [38:0] expected [$]; // {rd, illegal, invalid, data} in issue order.
    int          waited;

    FpClockGen i_FpClockGen (.clk(clk), .rstN(rstN));

    FpMiscUnit i_FpMiscUnit (.*);

    bind FpMiscUnit FpMiscUnitAssert i_FpMiscUnitAssert (.*);

    function automatic logic [31:0] encode(logic [6:0] f7, logic [2:0] f3, logic [4:0] rs2);
        return {f7, rs2, 5'd7, f3, 5'd0, 7'b1010011}; // rd filled in later.
    endfunction

    // one-hot fclass mask from the field rules.
    function automatic logic [9:0] classify(logic [31:0] w);
        if (w[30:23] == 8'hFF && w[22:0] != 23'd0) return w[22] ? 10'h200 : 10'h100;
        if (w[30:23] == 8'hFF) return w[31] ? 10'h001 : 10'h080;
        if (w[30:0] == 31'd0) return w[31] ? 10'h008 : 10'h010;
        if (w[30:23] == 8'h00) return w[31] ? 10'h004 : 10'h020;
        return w[31] ? 10'h002 : 10'h040;
    endfunction

    // monotonic key, -0 sorts just below +0.
    function automatic logic [31:0] orderKey(logic [31:0] w);
        return w[31] ? ~w : {1'b1, w[30:0]};
    endfunction

    // reference result {illegal, invalid, data}.
    function automatic logic [33:0] predict(logic [31:0] ins, logic [31:0] a, logic [31:0] b);
        logic [9:0]  classA;
        logic [9:0]  classB;
        logic        nanA;
        logic        nanB;
        logic        sig;
        logic        eq;
        logic        lt;
        logic [31:0] lo;
        logic [31:0] hi;
        classA = classify(a);
        classB = classify(b);
        nanA = |classA[9:8];
        nanB = |classB[9:8];
        sig  = classA[8] | classB[8];
        eq   = !(nanA || nanB) && (a == b || (a[30:0] == 31'd0 && b[30:0] == 31'd0));
        lt   = !(nanA || nanB) && !eq && orderKey(a) < orderKey(b);
        lo   = (orderKey(a) <= orderKey(b)) ? a : b;
        hi   = (orderKey(a) <= orderKey(b)) ? b : a;
        if (nanA && nanB) begin
            lo = 32'h7FC0_0000;
            hi = 32'h7FC0_0000;
        end else if (nanA || nanB) begin
            lo = nanA ? b : a; // the number is returned.
            hi = lo;
        end
        if (ins[6:0] != 7'b1010011) return {2'b10, 32'd0};
        case ({ins[31:25], ins[14:12]})
            {F7SGNJ, 3'd0}:   return {2'b00, b[31], a[30:0]};
            {F7SGNJ, 3'd1}:   return {2'b00, ~b[31], a[30:0]};
            {F7SGNJ, 3'd2}:   return {2'b00, a[31] ^ b[31], a[30:0]};
            {F7MINMAX, 3'd0}: return {1'b0, sig, lo};
            {F7MINMAX, 3'd1}: return {1'b0, sig, hi};
            {F7CMP, 3'd2}:    return {1'b0, sig, 31'd0, eq};
            {F7CMP, 3'd1}:    return {1'b0, nanA | nanB, 31'd0, lt};
            {F7CMP, 3'd0}:    return {1'b0, nanA | nanB, 31'd0, lt | eq};
            {F7CLS, 3'd1}:    return (ins[24:20] == 5'd0) ? {24'd0, classA} : {2'b10, 32'd0};
            {F7CLS, 3'd0}, {F7MVWX, 3'd0}:
                return (ins[24:20] == 5'd0) ? {2'b00, a} : {2'b10, 32'd0};
            default:          return {2'b10, 32'd0};
        endcase
    endfunction

    function automatic logic [31:0] randomOperand();
        if ($urandom % 2 == 0) return SPECIALS[$urandom % 10];
        return $urandom;
    endfunction

    task automatic stopOnFailure();
        $display("TB FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            stopOnFailure();
        end
    endtask

    task automatic addEntry(
        input logic [31:0] ins,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [31:0] data,
        input logic [1:0]  flags
    );
        stimEntry_t e;
        e = '{ins, a, b, data, flags};
        e.instr[11:7] = 5'(stimTable.size() + 1); // distinct rd per row.
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'hFF80_0000, 32'h0, 32'h0000_0001, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'hBF80_0000, 32'h0, 32'h0000_0002, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h8000_0001, 32'h0, 32'h0000_0004, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h8000_0000, 32'h0, 32'h0000_0008, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h0000_0000, 32'h0, 32'h0000_0010, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h0000_0001, 32'h0, 32'h0000_0020, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h3F80_0000, 32'h0, 32'h0000_0040, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h7F80_0000, 32'h0, 32'h0000_0080, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h7F80_0001, 32'h0, 32'h0000_0100, 2'b00);
        addEntry(encode(F7CLS, 3'd1, 5'd0), 32'h7FC0_0000, 32'h0, 32'h0000_0200, 2'b00);
        addEntry(encode(F7SGNJ, 3'd0, 5'd0), 32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, 2'b00);
        addEntry(encode(F7SGNJ, 3'd1, 5'd0), 32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000, 2'b00);
        addEntry(encode(F7SGNJ, 3'd2, 5'd0), 32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, 2'b00);
        addEntry(encode(F7CLS, 3'd0, 5'd0), 32'hDEAD_BEEF, 32'h0, 32'hDEAD_BEEF, 2'b00);
        addEntry(encode(F7MVWX, 3'd0, 5'd0), 32'h1234_5678, 32'h0, 32'h1234_5678, 2'b00);
        addEntry(encode(F7MINMAX, 3'd0, 5'd0), 32'h3F80_0000, 32'h4000_0000, 32'h3F80_0000, 2'b00);
        addEntry(encode(F7MINMAX, 3'd1, 5'd0), 32'h3F80_0000, 32'h4000_0000, 32'h4000_0000, 2'b00);
        addEntry(encode(F7MINMAX, 3'd0, 5'd0), 32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 2'b00);
        addEntry(encode(F7MINMAX, 3'd1, 5'd0), 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 2'b00);
        addEntry(encode(F7MINMAX, 3'd0, 5'd0), 32'h7FC0_0000, 32'h4000_0000, 32'h4000_0000, 2'b00);
        addEntry(encode(F7MINMAX, 3'd0, 5'd0), 32'h7FC0_0000, 32'h7F80_0001, 32'h7FC0_0000, 2'b01);
        addEntry(encode(F7MINMAX, 3'd1, 5'd0), 32'h7F80_0001, 32'h3F80_0000, 32'h3F80_0000, 2'b01);
        addEntry(encode(F7CMP, 3'd2, 5'd0), 32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 2'b00);
        addEntry(encode(F7CMP, 3'd2, 5'd0), 32'h7FC0_0000, 32'h3F80_0000, 32'h0000_0000, 2'b00);
        addEntry(encode(F7CMP, 3'd2, 5'd0), 32'h7F80_0001, 32'h3F80_0000, 32'h0000_0000, 2'b01);
        addEntry(encode(F7CMP, 3'd1, 5'd0), 32'hBF80_0000, 32'h3F80_0000, 32'h0000_0001, 2'b00);
        addEntry(encode(F7CMP, 3'd1, 5'd0), 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 2'b00);
        addEntry(encode(F7CMP, 3'd1, 5'd0), 32'h7FC0_0000, 32'h3F80_0000, 32'h0000_0000, 2'b01);
        addEntry(encode(F7CMP, 3'd0, 5'd0), 32'h8000_0000, 32'h0000_0000, 32'h0000_0001, 2'b00);
        addEntry(encode(F7CMP, 3'd0, 5'd0), 32'h4000_0000, 32'h3F80_0000, 32'h0000_0000, 2'b00);
        addEntry(encode(F7CMP, 3'd0, 5'd0), 32'h3F80_0000, 32'h7FC0_0000, 32'h0000_0000, 2'b01);
        // system opcode, rs2 nonzero on fclass, unknown funct3.
        addEntry(encode(F7SGNJ, 3'd0, 5'd0) ^ 32'h20, 32'h7F80_0001, 32'h0, 32'h0, 2'b10);
        addEntry(encode(F7CLS, 3'd1, 5'd1), 32'h7F80_0001, 32'h0, 32'h0, 2'b10);
        addEntry(encode(F7SGNJ, 3'd3, 5'd0), 32'h7F80_0001, 32'h0, 32'h0, 2'b10);
    endtask

    task automatic issueOp(logic [31:0] ins, logic [31:0] a, logic [31:0] b, logic [38:0] exp);
        @(posedge clk);
        #2;
        issueValid = 1'b1;
        instr      = ins;
        srcA       = a;
        srcB       = b;
        expected.push_back(exp);
    endtask

    task automatic driveAll();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [9:0]  pick;
        foreach (stimTable[i]) begin
            issueOp(stimTable[i].instr, stimTable[i].srcA, stimTable[i].srcB,
                    {stimTable[i].instr[11:7], stimTable[i].flags, stimTable[i].data});
        end
        repeat (200) begin // back-to-back random stream.
            pick = LEGAL_OPS[$urandom % 11];
            ins  = {pick[9:3], (pick[9:3] < F7CLS) ? 5'($urandom) : 5'd0, 5'($urandom),
                    pick[2:0], 5'($urandom), 7'b1010011};
            a    = randomOperand();
            b    = randomOperand();
            issueOp(ins, a, b, {ins[11:7], predict(ins, a, b)});
        end
        @(posedge clk);
        #2 issueValid = 1'b0;
    endtask

    task automatic collectResults(int count);
        logic [38:0] exp;
        int          n;
        int          cycles;
        for (n = 0; n < count; n++) begin
            cycles = 0;
            do begin
                @(negedge clk); // outputs settle mid-cycle.
                cycles++;
            end while (!resultValid && cycles < TIMEOUT);
            if (!resultValid) begin
                $display("no result arrived within %0d cycles for operation %0d", TIMEOUT, n);
                stopOnFailure();
            end
            if (expected.size() == 0) begin
                $display("a result arrived with no operation outstanding");
                stopOnFailure();
            end
            exp = expected.pop_front();
            check("resultData", resultData, exp[31:0]);
            check("resultInvalid", 32'(resultInvalid), 32'(exp[32]));
            check("illegalInstr", 32'(illegalInstr), 32'(exp[33]));
            check("resultRd", 32'(resultRd), 32'(exp[38:34]));
        end
    endtask

    initial begin
        issueValid = 1'b0;
        instr      = '0;
        srcA       = '0;
        srcB       = '0;
        void'($urandom(32'h0523a0b7));
        buildTable();
        waited = 0;
        while (rstN !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("reset was never released");
            stopOnFailure();
        end
        fork
            driveAll();
            collectResults(stimTable.size() + 200);
        join
        if (i_FpMiscUnit.i_FpMiscUnitAssert.failCount != 0) begin
            $display("assertion failures were reported during the run");
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end
endmodule

//--- tb/FpMiscUnit_assert.sv
// concurrent port checks for the misc unit, attached by bind.

`timescale 1ns/1ps

module FpMiscUnitAssert (
    input logic clk,
    input logic rstN,
    input logic issueValid,
    input logic resultValid,
    input logic resultInvalid,
    input logic illegalInstr
);
    int failCount = 0; // number of failed assertions.

    // two register stages between issue and result.
    validLatency: assert property (@(posedge clk) disable iff (!rstN)
        resultValid == $past(issueValid, 2))
        else begin
            failCount++;
            $error("resultValid does not trail issueValid by two cycles");
        end

    // flags are qualified by the strobe.
    flagsQualified: assert property (@(posedge clk) disable iff (!rstN)
        (illegalInstr || resultInvalid) |-> resultValid)
        else begin
            failCount++;
            $error("a flag is high without resultValid");
        end

    idleInReset: assert property (@(posedge clk) !rstN |=> !resultValid)
        else begin
            failCount++;
            $error("resultValid is high after a reset cycle");
        end
endmodule

//--- verilog/FpClassifier.sv
// single precision classifier producing the one-hot FCLASS mask.

`timescale 1ns/1ps

module FpClassifier import FpTypes::*; (
    input  fpWord_u    src,
    output logic [9:0] classMask
);
    logic expZero;  // exponent all zeros.
    logic expOnes;  // exponent all ones.
    logic fracZero; // no fraction bits set.

    assign expZero  = (src.f.exponent == 8'h00);
    assign expOnes  = (src.f.exponent == 8'hFF);
    assign fracZero = (src.f.fraction == 23'd0);

    always_comb begin
        classMask = '0;
        if (expOnes && !fracZero) begin
            // NaN ignores the sign.
            if (src.f.fraction[22]) classMask[CLASS_QNAN] = 1'b1;
            else classMask[CLASS_SNAN] = 1'b1;
        end else if (expOnes) begin
            if (src.f.sign) classMask[CLASS_NEG_INF] = 1'b1;
            else classMask[CLASS_POS_INF] = 1'b1;
        end else if (expZero && fracZero) begin
            if (src.f.sign) classMask[CLASS_NEG_ZERO] = 1'b1;
            else classMask[CLASS_POS_ZERO] = 1'b1;
        end else if (expZero) begin
            if (src.f.sign) classMask[CLASS_NEG_SUBNORMAL] = 1'b1;
            else classMask[CLASS_POS_SUBNORMAL] = 1'b1;
        end else begin
            // exponent strictly inside the range.
            if (src.f.sign) classMask[CLASS_NEG_NORMAL] = 1'b1;
            else classMask[CLASS_POS_NORMAL] = 1'b1;
        end
    end
endmodule

//--- verilog/FpCompareUnit.sv
// float comparator with min/max selection and NV detection.

`timescale 1ns/1ps

module FpCompareUnit import FpTypes::*; (
    input  fpWord_u     a,
    input  fpWord_u     b,
    input  logic [9:0]  aClass,
    input  logic [9:0]  bClass,
    output logic        isEq,
    output logic        isLt,
    output logic [31:0] minWord,
    output logic [31:0] maxWord,
    output logic        eqInvalid,
    output logic        ordInvalid
);
    logic aNan;
    logic bNan;
    logic anyNan;
    logic bothZero;  // +0 and -0 in any mix.
    logic magLt;     // |a| < |b|.
    logic magGt;     // |a| > |b|.
    logic totalLt;   // a below b with -0 below +0.

    assign aNan   = aClass[CLASS_SNAN] | aClass[CLASS_QNAN];
    assign bNan   = bClass[CLASS_SNAN] | bClass[CLASS_QNAN];
    assign anyNan = aNan | bNan;

    assign bothZero = (aClass[CLASS_NEG_ZERO] | aClass[CLASS_POS_ZERO])
                    & (bClass[CLASS_NEG_ZERO] | bClass[CLASS_POS_ZERO]);

    // exponent and fraction order like an unsigned integer.
    assign magLt = a.raw[30:0] < b.raw[30:0];
    assign magGt = a.raw[30:0] > b.raw[30:0];

    always_comb begin
        if (a.f.sign != b.f.sign) begin
            totalLt = a.f.sign;  // negative side is lower.
        end else if (a.f.sign) begin
            totalLt = magGt;     // both negative so larger magnitude is lower.
        end else begin
            totalLt = magLt;
        end
    end

    // ordered results are false on any NaN.
    assign isEq = !anyNan && (bothZero || a.raw == b.raw);
    assign isLt = !anyNan && !bothZero && totalLt;

    always_comb begin
        if (aNan && bNan) begin
            minWord = CANONICAL_NAN;
            maxWord = CANONICAL_NAN;
        end else if (aNan) begin
            minWord = b.raw; // the number wins over a NaN.
            maxWord = b.raw;
        end else if (bNan) begin
            minWord = a.raw;
            maxWord = a.raw;
        end else begin
            minWord = totalLt ? a.raw : b.raw;
            maxWord = totalLt ? b.raw : a.raw;
        end
    end

    assign eqInvalid  = aClass[CLASS_SNAN] | bClass[CLASS_SNAN]; // quiet compare.
    assign ordInvalid = anyNan;                                 // signaling compare.
endmodule

//--- verilog/FpExecUnit.sv
// execute stage selecting the result word and flags per operation.

`timescale 1ns/1ps

module FpExecUnit import FpTypes::*; (
    FpIssueIf.exe  issue,
    FpResultIf.exe result
);
    logic [9:0]  aClass;
    logic [9:0]  bClass;
    logic        isEq;
    logic        isLt;
    logic [31:0] minWord;
    logic [31:0] maxWord;
    logic        eqInvalid;
    logic        ordInvalid;
    logic        sNanSeen;  // either source is a signaling NaN.

    FpClassifier i_aClassifier (
        .src       (issue.a),
        .classMask (aClass)
    );

    FpClassifier i_bClassifier (
        .src       (issue.b),
        .classMask (bClass)
    );

    FpCompareUnit i_FpCompareUnit (
        .a          (issue.a),
        .b          (issue.b),
        .aClass     (aClass),
        .bClass     (bClass),
        .isEq       (isEq),
        .isLt       (isLt),
        .minWord    (minWord),
        .maxWord    (maxWord),
        .eqInvalid  (eqInvalid),
        .ordInvalid (ordInvalid)
    );

    assign sNanSeen = aClass[CLASS_SNAN] | bClass[CLASS_SNAN];

    always_comb begin
        result.data    = '0;
        result.invalid = 1'b0;
        result.illegal = 1'b0;
        case (issue.op)
            OP_CLASS: result.data = {22'd0, aClass};
            // sign injection keeps the magnitude of a.
            OP_SGNJ:  result.data = {issue.b.f.sign, issue.a.raw[30:0]};
            OP_SGNJN: result.data = {~issue.b.f.sign, issue.a.raw[30:0]};
            OP_SGNJX: result.data = {issue.a.f.sign ^ issue.b.f.sign, issue.a.raw[30:0]};
            OP_MIN: begin
                result.data    = minWord;
                result.invalid = sNanSeen;
            end
            OP_MAX: begin
                result.data    = maxWord;
                result.invalid = sNanSeen;
            end
            OP_EQ: begin
                result.data    = {31'd0, isEq};
                result.invalid = eqInvalid;
            end
            OP_LT: begin
                result.data    = {31'd0, isLt};
                result.invalid = ordInvalid;
            end
            OP_LE: begin
                result.data    = {31'd0, isLt | isEq};
                result.invalid = ordInvalid;
            end
            OP_MVXW, OP_MVWX: result.data = issue.a.raw; // bit pattern moves untouched.
            default: result.illegal = 1'b1;                // data stays zero.
        endcase
    end

    assign result.valid = issue.valid;
    assign result.rd    = issue.rd;
endmodule

//--- verilog/FpMiscUnit.sv
// top level of the floating-point misc unit with decode, execute and result stages.

`timescale 1ns/1ps

module FpMiscUnit (
    input  logic        clk,
    input  logic        rstN,
    input  logic        issueValid,
    input  logic [31:0] instr,
    input  logic [31:0] srcA,
    input  logic [31:0] srcB,
    output logic        resultValid,
    output logic [4:0]  resultRd,
    output logic [31:0] resultData,
    output logic        resultInvalid,
    output logic        illegalInstr
);
    FpIssueIf  issueBus ();  // decode to execute.
    FpResultIf resultBus (); // execute to result.

    FpOpDecoder i_FpOpDecoder (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .instr      (instr),
        .srcA       (srcA),
        .srcB       (srcB),
        .issue      (issueBus.dec)
    );

    FpExecUnit i_FpExecUnit (
        .issue  (issueBus.exe),
        .result (resultBus.exe)
    );

    FpResultStage i_FpResultStage (
        .clk           (clk),
        .rstN          (rstN),
        .result        (resultBus.res),
        .resultValid   (resultValid),
        .resultRd      (resultRd),
        .resultData    (resultData),
        .resultInvalid (resultInvalid),
        .illegalInstr  (illegalInstr)
    );
endmodule

//--- verilog/FpOpDecoder.sv
// OP-FP instruction decoder with the issue register stage.

`timescale 1ns/1ps

module FpOpDecoder import FpTypes::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        issueValid,
    input  logic [31:0] instr,
    input  logic [31:0] srcA,
    input  logic [31:0] srcB,
    FpIssueIf.dec       issue
);
    // funct7 groups of the misc ops.
    localparam logic [6:0] FUNCT7_SGNJ   = 7'b0010000;
    localparam logic [6:0] FUNCT7_MINMAX = 7'b0010100;
    localparam logic [6:0] FUNCT7_CMP    = 7'b1010000;
    localparam logic [6:0] FUNCT7_CLSMVX = 7'b1110000;
    localparam logic [6:0] FUNCT7_MVWX   = 7'b1111000;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs2;
    logic [6:0] funct7;
    fpOp_e      decOp;

    // R-type fields.
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        decOp = OP_ILLEGAL; // default for unknown words.
        if (opcode == OPCODE_OP_FP) begin
            case (funct7)
                FUNCT7_SGNJ: begin
                    if (funct3 == 3'd0) decOp = OP_SGNJ;
                    else if (funct3 == 3'd1) decOp = OP_SGNJN;
                    else if (funct3 == 3'd2) decOp = OP_SGNJX;
                end
                FUNCT7_MINMAX: begin
                    if (funct3 == 3'd0) decOp = OP_MIN;
                    else if (funct3 == 3'd1) decOp = OP_MAX;
                end
                FUNCT7_CMP: begin
                    if (funct3 == 3'd2) decOp = OP_EQ;
                    else if (funct3 == 3'd1) decOp = OP_LT;
                    else if (funct3 == 3'd0) decOp = OP_LE;
                end
                FUNCT7_CLSMVX: begin
                    // rs2 field must be zero here.
                    if (rs2 == 5'd0 && funct3 == 3'd1) decOp = OP_CLASS;
                    else if (rs2 == 5'd0 && funct3 == 3'd0) decOp = OP_MVXW;
                end
                FUNCT7_MVWX: begin
                    if (rs2 == 5'd0 && funct3 == 3'd0) decOp = OP_MVWX;
                end
                default: decOp = OP_ILLEGAL;
            endcase
        end
    end

    // issue strobe.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= issueValid;
        end
    end

    // payload is only loaded on an issue.
    always_ff @(posedge clk) begin
        if (issueValid) begin
            issue.op    <= decOp;
            issue.rd    <= instr[11:7];
            issue.a.raw <= srcA;  // integer bits, float view read later.
            issue.b.raw <= srcB;
        end
    end
endmodule

//--- verilog/FpPipeIf.sv
// issue bundle (decode to execute) and result bundle (execute to result) interfaces.

`timescale 1ns/1ps

interface FpIssueIf import FpTypes::*; ();
    logic    valid; // registered issue strobe.
    fpOp_e   op;    // decoded operation.
    logic [4:0] rd; // destination register.
    fpWord_u a;     // rs1 value.
    fpWord_u b;     // rs2 value.

    modport dec (
        output valid,
        output op,
        output rd,
        output a,
        output b
    );

    modport exe (
        input valid,
        input op,
        input rd,
        input a,
        input b
    );
endinterface

interface FpResultIf ();
    logic        valid;   // follows the issue strobe.
    logic [4:0]  rd;
    logic [31:0] data;    // integer or float result word.
    logic        invalid; // NV flag.
    logic        illegal; // op was OP_ILLEGAL.

    modport exe (
        output valid,
        output rd,
        output data,
        output invalid,
        output illegal
    );

    modport res (
        input valid,
        input rd,
        input data,
        input invalid,
        input illegal
    );
endinterface

//--- verilog/FpResultStage.sv
// output register stage for the result bundle.

`timescale 1ns/1ps

module FpResultStage (
    input  logic        clk,
    input  logic        rstN,
    FpResultIf.res      result,
    output logic        resultValid,
    output logic [4:0]  resultRd,
    output logic [31:0] resultData,
    output logic        resultInvalid,
    output logic        illegalInstr
);
    logic        validQ;
    logic [4:0]  rdQ;
    logic [31:0] dataQ;
    logic        invalidQ;
    logic        illegalQ;

    always_ff @(posedge clk) begin
        if (!rstN) validQ <= 1'b0;
        else validQ <= result.valid;
    end

    always_ff @(posedge clk) begin
        rdQ      <= result.rd;
        dataQ    <= result.data;
        invalidQ <= result.invalid;
        illegalQ <= result.illegal;
    end

    assign resultValid   = validQ;
    assign resultRd      = rdQ;
    assign resultData    = dataQ;
    assign resultInvalid = validQ & invalidQ; // flags only with the strobe.
    assign illegalInstr  = validQ & illegalQ;
endmodule

//--- verilog/FpTypes.sv
// operation enum, FCLASS bit positions, single precision word union and canonical NaN.

package FpTypes;

    // major opcode of all OP-FP instructions.
    localparam logic [6:0] OPCODE_OP_FP = 7'b1010011;

    // operations handled by the misc unit.
    typedef enum logic [3:0] {
        OP_CLASS   = 4'd0,  // fclass.s.
        OP_SGNJ    = 4'd1,  // fsgnj.s.
        OP_SGNJN   = 4'd2,  // fsgnjn.s.
        OP_SGNJX   = 4'd3,  // fsgnjx.s.
        OP_MIN     = 4'd4,  // fmin.s.
        OP_MAX     = 4'd5,  // fmax.s.
        OP_EQ      = 4'd6,  // feq.s.
        OP_LT      = 4'd7,  // flt.s.
        OP_LE      = 4'd8,  // fle.s.
        OP_MVXW    = 4'd9,  // fmv.x.w.
        OP_MVWX    = 4'd10, // fmv.w.x.
        OP_ILLEGAL = 4'd15  // anything the decoder does not know.
    } fpOp_e;

    // bit positions in the 10-bit fclass mask.
    localparam int CLASS_NEG_INF       = 0;
    localparam int CLASS_NEG_NORMAL    = 1;
    localparam int CLASS_NEG_SUBNORMAL = 2;
    localparam int CLASS_NEG_ZERO      = 3;
    localparam int CLASS_POS_ZERO      = 4;
    localparam int CLASS_POS_SUBNORMAL = 5;
    localparam int CLASS_POS_NORMAL    = 6;
    localparam int CLASS_POS_INF       = 7;
    localparam int CLASS_SNAN          = 8;
    localparam int CLASS_QNAN          = 9;

    // one source register, seen as an integer or as a float.
    typedef union packed {
        logic [31:0] raw;          // integer view.
        struct packed {
            logic        sign;     // bit 31.
            logic [7:0]  exponent; // biased exponent.
            logic [22:0] fraction; // top bit is the quiet bit for NaN.
        } f;
    } fpWord_u;

    // quiet NaN returned by fmin/fmax when both inputs are NaN.
    localparam logic [31:0] CANONICAL_NAN = 32'h7FC0_0000;

endpackage
